// File: persona_pkg.sv
// Shared widths, register map and mover states; offsets are word addresses in the persona window
`default_nettype none

package persona_pkg;

   // Bus widths, with the register window already cut down to 14 bits by the wrapper
   localparam int csr_addr_w  = 14;
   localparam int csr_data_w  = 32;
   localparam int emif_addr_w = 25;
   localparam int emif_data_w = 512;
   localparam int operand_w   = 16;
   localparam int product_w   = 32;

   typedef logic [csr_addr_w-1:0]  csr_addr_t;
   typedef logic [csr_data_w-1:0]  csr_data_t;
   typedef logic [emif_addr_w-1:0] emif_addr_t;
   typedef logic [emif_data_w-1:0] emif_data_t;
   typedef logic [operand_w-1:0]   operand_t;
   typedef logic [product_w-1:0]   product_t;

   // Register offsets
   localparam csr_addr_t reg_operand_a   = 14'd0;
   localparam csr_addr_t reg_operand_b   = 14'd1;
   localparam csr_addr_t reg_product     = 14'd2;
   localparam csr_addr_t reg_emif_addr   = 14'd3;
   localparam csr_addr_t reg_command     = 14'd4;
   localparam csr_addr_t reg_status      = 14'd5;
   localparam csr_addr_t reg_persona_id  = 14'd6;
   localparam csr_addr_t reg_loaded_word = 14'd7;

   // Identifier returned by reg_persona_id so software can tell which persona is loaded
   localparam csr_data_t persona_id = 32'hD5B0_0001;

   // Cycles from a mult_start write to the product showing up in reg_product
   localparam int mult_latency = 3;

   // Bit positions in reg_command
   localparam int cmd_mult_start_bit = 0;
   localparam int cmd_store_bit      = 1;
   localparam int cmd_load_bit       = 2;

   // Bit positions in reg_status
   localparam int status_product_valid_bit = 0;
   localparam int status_mover_busy_bit    = 1;
   localparam int status_mover_done_bit    = 2;

   typedef enum logic [1:0] {
      idle,
      write_wait,
      read_wait,
      read_data
   } mover_state_t;

endpackage

`default_nettype wire

// File: csr_bus_if.sv
// Register bus inside the persona; the core never stalls after the first cycle out of reset
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if;

   // Request side, driven by the wrapper
   logic                   read;
   logic                   write;
   persona_pkg::csr_addr_t address;
   persona_pkg::csr_data_t writedata;

   // Response side, driven by the core
   persona_pkg::csr_data_t readdata;
   logic                   readdatavalid;
   logic                   waitrequest;

   // The wrapper issues reads and writes
   modport host (
      output read, write, address, writedata,
      input  readdata, readdatavalid, waitrequest
   );

   // The persona core answers them
   modport agent (
      input  read, write, address, writedata,
      output readdata, readdatavalid, waitrequest
   );

endinterface

`default_nettype wire

// File: emif_bus_if.sv
// Single-beat, full-width memory bus; no burst or byte-enable signals are carried
`timescale 1ns/1ps
`default_nettype none

interface emif_bus_if;

   logic                    read;
   logic                    write;
   persona_pkg::emif_addr_t address;
   persona_pkg::emif_data_t writedata;
   persona_pkg::emif_data_t readdata;
   logic                    readdatavalid;
   logic                    waitrequest;

   // The mover holds its request and address until waitrequest is seen low
   modport master (
      output read, write, address, writedata,
      input  readdata, readdatavalid, waitrequest
   );

   // The wrapper side faces the external memory controller
   modport slave (
      input  read, write, address, writedata,
      output readdata, readdatavalid, waitrequest
   );

endinterface

`default_nettype wire

// File: dsp_mult_pipe.sv
// Unsigned 16x16 multiplier, three stages deep; a new pair every cycle and results in order
`timescale 1ns/1ps
`default_nettype none

module dsp_mult_pipe (
   input  wire                          pr_region_clk,
   input  wire                          rst,
   input  wire                          start,
   input  wire persona_pkg::operand_t   operand_a,
   input  wire persona_pkg::operand_t   operand_b,
   output persona_pkg::product_t        product,
   output logic                         product_strobe
);

   // Stage 1 holds the operands
   persona_pkg::operand_t a_s1;
   persona_pkg::operand_t b_s1;
   logic                  v_s1;
   // Stage 2 holds two partial products, one per byte of operand B
   logic [23:0]           pp_lo_s2;
   logic [23:0]           pp_hi_s2;
   logic                  v_s2;
   // Stage 3 holds the summed result
   persona_pkg::product_t p_s3;
   logic                  v_s3;

   // Valid bits move down the stages in step with their data
   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         v_s1 <= 1'b0;
         v_s2 <= 1'b0;
         v_s3 <= 1'b0;
      end else begin
         v_s1 <= start;
         v_s2 <= v_s1;
         v_s3 <= v_s2;
      end
   end

   always_ff @(posedge pr_region_clk) begin
      a_s1     <= operand_a;
      b_s1     <= operand_b;
      pp_lo_s2 <= a_s1 * b_s1[7:0];
      pp_hi_s2 <= a_s1 * b_s1[15:8];
      // High partial product is shifted up one byte before the add
      p_s3     <= {8'd0, pp_lo_s2} + {pp_hi_s2, 8'd0};
   end

   assign product        = p_s3;
   assign product_strobe = v_s3;

endmodule

`default_nettype wire

// File: emif_result_mover.sv
// Moves one product to DDR or one word back from it; commands that arrive while busy are dropped
`timescale 1ns/1ps
`default_nettype none

module emif_result_mover (
   input  wire                          pr_region_clk,
   input  wire                          rst,
   input  wire                          store,
   input  wire                          load,
   input  wire persona_pkg::emif_addr_t address,
   input  wire persona_pkg::product_t   product,
   emif_bus_if.master                   emif,
   output persona_pkg::csr_data_t       loaded_word,
   output logic                         busy,
   output logic                         done
);

   persona_pkg::mover_state_t state_q;
   persona_pkg::emif_addr_t   addr_q;
   persona_pkg::product_t     data_q;
   persona_pkg::csr_data_t    loaded_q;
   logic                      done_q;

   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         state_q <= persona_pkg::idle;
         done_q  <= 1'b0;
      end else begin
         case (state_q)
            persona_pkg::idle: begin
               // Store takes priority if both bits are set in the same command
               if (store) begin
                  state_q <= persona_pkg::write_wait;
                  done_q  <= 1'b0;
               end else if (load) begin
                  state_q <= persona_pkg::read_wait;
                  done_q  <= 1'b0;
               end
            end
            persona_pkg::write_wait: begin
               if (!emif.waitrequest) begin
                  state_q <= persona_pkg::idle;
                  done_q  <= 1'b1;
               end
            end
            persona_pkg::read_wait: begin
               // Read accepted, the data follows on a later cycle
               if (!emif.waitrequest) begin
                  state_q <= persona_pkg::read_data;
               end
            end
            persona_pkg::read_data: begin
               if (emif.readdatavalid) begin
                  state_q <= persona_pkg::idle;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= persona_pkg::idle;
         endcase
      end
   end

   // Address and product are captured once, so later register writes cannot disturb a transfer
   always_ff @(posedge pr_region_clk) begin
      if (state_q == persona_pkg::idle && (store || load)) begin
         addr_q <= address;
         data_q <= product;
      end
      if (state_q == persona_pkg::read_data && emif.readdatavalid) begin
         loaded_q <= emif.readdata[31:0];
      end
   end

   // Request lines come straight from the state, so they hold until waitrequest drops
   assign emif.write     = (state_q == persona_pkg::write_wait);
   assign emif.read      = (state_q == persona_pkg::read_wait);
   assign emif.address   = addr_q;
   // Product sits in the low 32 bits of the word, the rest is zero
   assign emif.writedata = persona_pkg::emif_data_t'(data_q);

   assign loaded_word = loaded_q;
   assign busy        = (state_q != persona_pkg::idle);
   assign done        = done_q;

endmodule

`default_nettype wire

// File: basic_dsp_persona.sv
// Persona core; read data returns one cycle after each accepted read, and unmapped reads give zero
`timescale 1ns/1ps
`default_nettype none

module basic_dsp_persona (
   input  wire        pr_region_clk,
   input  wire        rst,
   csr_bus_if.agent   csr,
   emif_bus_if.master emif
);

   logic                    wait_q;
   logic                    rd_accept;
   logic                    wr_accept;
   logic                    cmd_write;
   logic                    mult_start;
   logic                    store_cmd;
   logic                    load_cmd;
   persona_pkg::csr_data_t  operand_a_q;
   persona_pkg::csr_data_t  operand_b_q;
   persona_pkg::emif_addr_t emif_addr_q;
   persona_pkg::product_t   mult_product;
   logic                    mult_strobe;
   persona_pkg::product_t   product_q;
   logic                    product_valid_q;
   persona_pkg::csr_data_t  loaded_word;
   logic                    mover_busy;
   logic                    mover_done;
   persona_pkg::csr_data_t  status_word;
   persona_pkg::csr_data_t  rd_mux;
   persona_pkg::csr_data_t  readdata_q;
   logic                    readdatavalid_q;

   // Stall the bus during reset and one cycle beyond, then never again
   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         wait_q <= 1'b1;
      end else begin
         wait_q <= 1'b0;
      end
   end

   assign csr.waitrequest = wait_q;
   assign rd_accept       = csr.read & ~wait_q;
   assign wr_accept       = csr.write & ~wait_q;

   // Command bits turn into single-cycle pulses at the accepting edge
   assign cmd_write  = wr_accept && (csr.address == persona_pkg::reg_command);
   assign mult_start = cmd_write & csr.writedata[persona_pkg::cmd_mult_start_bit];
   assign store_cmd  = cmd_write & csr.writedata[persona_pkg::cmd_store_bit];
   assign load_cmd   = cmd_write & csr.writedata[persona_pkg::cmd_load_bit];

   // Writable registers
   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         operand_a_q <= '0;
         operand_b_q <= '0;
         emif_addr_q <= '0;
      end else if (wr_accept) begin
         case (csr.address)
            persona_pkg::reg_operand_a: operand_a_q <= csr.writedata;
            persona_pkg::reg_operand_b: operand_b_q <= csr.writedata;
            persona_pkg::reg_emif_addr: emif_addr_q <= persona_pkg::emif_addr_t'(csr.writedata);
            default: ;
         endcase
      end
   end

   // Operands enter the pipe from the register values held at the start edge
   dsp_mult_pipe u_mult (
      .pr_region_clk  (pr_region_clk),
      .rst            (rst),
      .start          (mult_start),
      .operand_a      (operand_a_q[15:0]),
      .operand_b      (operand_b_q[15:0]),
      .product        (mult_product),
      .product_strobe (mult_strobe)
   );

   // A new start invalidates the old product, and this wins over a strobe from an older pair
   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         product_q       <= '0;
         product_valid_q <= 1'b0;
      end else begin
         if (mult_strobe) begin
            product_q <= mult_product;
         end
         if (mult_start) begin
            product_valid_q <= 1'b0;
         end else if (mult_strobe) begin
            product_valid_q <= 1'b1;
         end
      end
   end

   emif_result_mover u_mover (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .store         (store_cmd),
      .load          (load_cmd),
      .address       (emif_addr_q),
      .product       (product_q),
      .emif          (emif),
      .loaded_word   (loaded_word),
      .busy          (mover_busy),
      .done          (mover_done)
   );

   always_comb begin
      status_word = '0;
      status_word[persona_pkg::status_product_valid_bit] = product_valid_q;
      status_word[persona_pkg::status_mover_busy_bit]    = mover_busy;
      status_word[persona_pkg::status_mover_done_bit]    = mover_done;
   end

   // Read mux; reg_command is write only and so falls into the zero default
   always_comb begin
      case (csr.address)
         persona_pkg::reg_operand_a:   rd_mux = operand_a_q;
         persona_pkg::reg_operand_b:   rd_mux = operand_b_q;
         persona_pkg::reg_product:     rd_mux = product_q;
         persona_pkg::reg_emif_addr:   rd_mux = persona_pkg::csr_data_t'(emif_addr_q);
         persona_pkg::reg_status:      rd_mux = status_word;
         persona_pkg::reg_persona_id:  rd_mux = persona_pkg::persona_id;
         persona_pkg::reg_loaded_word: rd_mux = loaded_word;
         default:                      rd_mux = '0;
      endcase
   end

   // The valid flag pulses for one cycle, the data word just holds its last value
   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         readdatavalid_q <= 1'b0;
      end else begin
         readdatavalid_q <= rd_accept;
      end
      if (rd_accept) begin
         readdata_q <= rd_mux;
      end
   end

   assign csr.readdata      = readdata_q;
   assign csr.readdatavalid = readdatavalid_q;

endmodule

`default_nettype wire

// File: basic_dsp_persona_top.sv
// Fixed PR wrapper; address bits 15:14 are ignored so each register shows up at four aliases
`timescale 1ns/1ps
`default_nettype none

module basic_dsp_persona_top (
   input  wire          pr_region_clk,
   input  wire          rst,

   // PR handshake with the static region
   input  wire          pr_handshake_start_req,
   input  wire          pr_handshake_stop_req,
   output logic         pr_handshake_start_ack,
   output logic         pr_handshake_stop_ack,

   // Register bus from the host
   input  wire          pr_region_avmm_read,
   input  wire          pr_region_avmm_write,
   input  wire [15:0]   pr_region_avmm_address,
   input  wire [31:0]   pr_region_avmm_writedata,
   output logic [31:0]  pr_region_avmm_readdata,
   output logic         pr_region_avmm_readdatavalid,
   output logic         pr_region_avmm_waitrequest,

   // External DDR memory bus
   output logic         emif_avmm_read,
   output logic         emif_avmm_write,
   output logic [24:0]  emif_avmm_address,
   output logic [511:0] emif_avmm_writedata,
   input  wire [511:0]  emif_avmm_readdata,
   input  wire          emif_avmm_readdatavalid,
   input  wire          emif_avmm_waitrequest
);

   csr_bus_if  csr_bus ();
   emif_bus_if emif_bus ();

   // Each ack follows its request one cycle later, in both directions
   always_ff @(posedge pr_region_clk) begin
      if (rst) begin
         pr_handshake_start_ack <= 1'b0;
         pr_handshake_stop_ack  <= 1'b0;
      end else begin
         pr_handshake_start_ack <= pr_handshake_start_req;
         pr_handshake_stop_ack  <= pr_handshake_stop_req;
      end
   end

   // Only the low 14 address bits reach the core, the top two select the region
   assign csr_bus.read      = pr_region_avmm_read;
   assign csr_bus.write     = pr_region_avmm_write;
   assign csr_bus.address   = pr_region_avmm_address[13:0];
   assign csr_bus.writedata = pr_region_avmm_writedata;

   // Responses pass straight out with no added cycle
   assign pr_region_avmm_readdata      = csr_bus.readdata;
   assign pr_region_avmm_readdatavalid = csr_bus.readdatavalid;
   assign pr_region_avmm_waitrequest   = csr_bus.waitrequest;

   // The memory interface maps one to one onto the DDR ports
   assign emif_avmm_read         = emif_bus.read;
   assign emif_avmm_write        = emif_bus.write;
   assign emif_avmm_address      = emif_bus.address;
   assign emif_avmm_writedata    = emif_bus.writedata;
   assign emif_bus.readdata      = emif_avmm_readdata;
   assign emif_bus.readdatavalid = emif_avmm_readdatavalid;
   assign emif_bus.waitrequest   = emif_avmm_waitrequest;

   basic_dsp_persona u_pr_core (
      .pr_region_clk (pr_region_clk),
      .rst           (rst),
      .csr           (csr_bus),
      .emif          (emif_bus)
   );

endmodule

`default_nettype wire

// File: tb_emif_model.sv
// DDR model; unwritten words read as zero and read data comes read_delay + 1 cycles after acceptance
`timescale 1ns/1ps
`default_nettype none

module tb_emif_model (
   input  wire          clk,
   input  wire          rst,
   input  wire          read,
   input  wire          write,
   input  wire [24:0]   address,
   input  wire [511:0]  writedata,
   output logic [511:0] readdata,
   output logic         readdatavalid,
   output logic         waitrequest,
   // Stall and latency settings come from the testbench
   input  wire [3:0]    stall_cycles,
   input  wire [3:0]    read_delay,
   // Backdoor write used to place a known word before a load
   input  wire          preload,
   input  wire [24:0]   preload_addr,
   input  wire [511:0]  preload_data
);

   logic [511:0] mem [logic [24:0]];
   logic         stalling;
   logic [3:0]   stall_left;
   logic         read_pending;
   logic [3:0]   delay_left;
   logic [511:0] read_word;
   logic         accept;

   // A fresh request is held off for stall_cycles cycles, then taken
   assign waitrequest = rst | ((read | write) &
                        (stalling ? (stall_left != 4'd0) : (stall_cycles != 4'd0)));
   assign accept      = (read | write) & ~waitrequest;

   function automatic logic [511:0] word_at(input logic [24:0] addr);
      return mem.exists(addr) ? mem[addr] : '0;
   endfunction

   function automatic logic holds_word(input logic [24:0] addr);
      return (mem.exists(addr) != 0);
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         stalling      <= 1'b0;
         stall_left    <= 4'd0;
         read_pending  <= 1'b0;
         delay_left    <= 4'd0;
         readdata      <= '0;
         readdatavalid <= 1'b0;
      end else begin
         readdatavalid <= 1'b0;
         // Count down the stall of the request that is waiting
         if ((read | write) && waitrequest) begin
            if (!stalling) begin
               stalling   <= 1'b1;
               stall_left <= stall_cycles - 4'd1;
            end else begin
               stall_left <= stall_left - 4'd1;
            end
         end else begin
            stalling <= 1'b0;
         end
         if (preload) begin
            mem[preload_addr] = preload_data;
         end
         if (accept && write) begin
            mem[address] = writedata;
         end
         // One read in flight at a time, which is all the mover issues
         if (accept && read) begin
            read_pending <= 1'b1;
            delay_left   <= read_delay;
            read_word    <= word_at(address);
         end else if (read_pending) begin
            if (delay_left == 4'd0) begin
               readdatavalid <= 1'b1;
               readdata      <= read_word;
               read_pending  <= 1'b0;
            end else begin
               delay_left <= delay_left - 4'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_basic_dsp_persona.sv
// Directed tests; inputs move 2 ns after the rising edge and outputs are read at the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_basic_dsp_persona;

   localparam int half_period = 20;
   localparam int drive_delay = 2;
   // Handshake, registers, ten multiplies and two polled transfers need a few hundred cycles
   localparam int timeout_cycles = 2000;
   localparam logic [31:0] lfsr_taps = 32'h8020_0003;

   logic         pr_region_clk;
   logic         rst;
   logic         start_req;
   logic         stop_req;
   logic         start_ack;
   logic         stop_ack;
   logic         avmm_read;
   logic         avmm_write;
   logic [15:0]  avmm_address;
   logic [31:0]  avmm_writedata;
   logic [31:0]  avmm_readdata;
   logic         avmm_readdatavalid;
   logic         avmm_waitrequest;
   logic         emif_read;
   logic         emif_write;
   logic [24:0]  emif_address;
   logic [511:0] emif_writedata;
   logic [511:0] emif_readdata;
   logic         emif_readdatavalid;
   logic         emif_waitrequest;
   logic [3:0]   stall_cycles;
   logic [3:0]   read_delay;
   logic         preload;
   logic [24:0]  preload_addr;
   logic [511:0] preload_data;
   logic [31:0]  lfsr_state;
   logic [24:0]  store_addr;
   int           error_count = 0;
   int           check_count = 0;
   int           cycle_count = 0;

   basic_dsp_persona_top dut_i (
      .pr_region_clk                (pr_region_clk),
      .rst                          (rst),
      .pr_handshake_start_req       (start_req),
      .pr_handshake_stop_req        (stop_req),
      .pr_handshake_start_ack       (start_ack),
      .pr_handshake_stop_ack        (stop_ack),
      .pr_region_avmm_read          (avmm_read),
      .pr_region_avmm_write         (avmm_write),
      .pr_region_avmm_address       (avmm_address),
      .pr_region_avmm_writedata     (avmm_writedata),
      .pr_region_avmm_readdata      (avmm_readdata),
      .pr_region_avmm_readdatavalid (avmm_readdatavalid),
      .pr_region_avmm_waitrequest   (avmm_waitrequest),
      .emif_avmm_read               (emif_read),
      .emif_avmm_write              (emif_write),
      .emif_avmm_address            (emif_address),
      .emif_avmm_writedata          (emif_writedata),
      .emif_avmm_readdata           (emif_readdata),
      .emif_avmm_readdatavalid      (emif_readdatavalid),
      .emif_avmm_waitrequest        (emif_waitrequest)
   );

   tb_emif_model mem_i (
      .clk           (pr_region_clk),
      .rst           (rst),
      .read          (emif_read),
      .write         (emif_write),
      .address       (emif_address),
      .writedata     (emif_writedata),
      .readdata      (emif_readdata),
      .readdatavalid (emif_readdatavalid),
      .waitrequest   (emif_waitrequest),
      .stall_cycles  (stall_cycles),
      .read_delay    (read_delay),
      .preload       (preload),
      .preload_addr  (preload_addr),
      .preload_data  (preload_data)
   );

   initial begin
      pr_region_clk = 1'b0;
      forever #half_period pr_region_clk = ~pr_region_clk;
   end

   // Ends a run that stops making progress
   always @(posedge pr_region_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == timeout_cycles) begin
         $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Galois LFSR that steps once for each bit taken
   function automatic logic [31:0] random_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value      = {value[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
      end
      return value;
   endfunction

   // Region bits 15:14 in front of a register offset
   function automatic logic [15:0] bus_addr(input logic [1:0] region,
                                            input persona_pkg::csr_addr_t offset);
      return {region, offset};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic step();
      @(posedge pr_region_clk);
      #drive_delay;
   endtask

   // Holds the request until an edge sees waitrequest low
   task automatic wait_accept();
      logic accepted;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge pr_region_clk);
         accepted = !avmm_waitrequest;
         step();
      end
   endtask

   task automatic csr_write(input logic [15:0] addr, input logic [31:0] data);
      avmm_write     = 1'b1;
      avmm_address   = addr;
      avmm_writedata = data;
      wait_accept();
      avmm_write = 1'b0;
   endtask

   task automatic csr_read(input logic [15:0] addr, output logic [31:0] data);
      avmm_read    = 1'b1;
      avmm_address = addr;
      wait_accept();
      avmm_read = 1'b0;
      // Read data must be valid in the cycle right after the accepting edge
      @(negedge pr_region_clk);
      check_value("pr_region_avmm_readdatavalid", 32'(avmm_readdatavalid), 32'd1);
      data = avmm_readdata;
      step();
   endtask

   task automatic run_multiply(input logic [31:0] a, input logic [31:0] b);
      csr_write(bus_addr(2'b00, persona_pkg::reg_operand_a), a);
      csr_write(bus_addr(2'b00, persona_pkg::reg_operand_b), b);
      csr_write(bus_addr(2'b00, persona_pkg::reg_command),
                32'd1 << persona_pkg::cmd_mult_start_bit);
      repeat (persona_pkg::mult_latency) step();
   endtask

   task automatic wait_mover_done();
      logic [31:0] status;
      status = '0;
      while (!status[persona_pkg::status_mover_done_bit]) begin
         csr_read(bus_addr(2'b00, persona_pkg::reg_status), status);
      end
      check_value("mover_busy at done", 32'(status[persona_pkg::status_mover_busy_bit]), 32'd0);
   endtask

   task automatic test_handshake();
      @(negedge pr_region_clk);
      check_value("pr_handshake_start_ack", 32'(start_ack), 32'd0);
      check_value("pr_handshake_stop_ack", 32'(stop_ack), 32'd0);
      check_value("pr_region_avmm_readdatavalid", 32'(avmm_readdatavalid), 32'd0);
      check_value("emif_avmm_read", 32'(emif_read), 32'd0);
      check_value("emif_avmm_write", 32'(emif_write), 32'd0);
      // The register bus still stalls in the first cycle out of reset
      check_value("pr_region_avmm_waitrequest", 32'(avmm_waitrequest), 32'd1);
      step();
      @(negedge pr_region_clk);
      check_value("pr_region_avmm_waitrequest", 32'(avmm_waitrequest), 32'd0);
      step();
      // Pass 0 works the start pair and pass 1 the stop pair
      for (int i = 0; i < 2; i++) begin
         if (i == 0) start_req = 1'b1;
         else stop_req = 1'b1;
         @(negedge pr_region_clk);
         check_value("ack before the edge", 32'(start_ack | stop_ack), 32'd0);
         step();
         @(negedge pr_region_clk);
         check_value("pr_handshake_start_ack", 32'(start_ack), 32'(i == 0));
         check_value("pr_handshake_stop_ack", 32'(stop_ack), 32'(i == 1));
         step();
         start_req = 1'b0;
         stop_req  = 1'b0;
         @(negedge pr_region_clk);
         check_value("ack held one cycle", 32'(start_ack | stop_ack), 32'd1);
         step();
         @(negedge pr_region_clk);
         check_value("ack after release", 32'(start_ack | stop_ack), 32'd0);
         step();
      end
   endtask

   // Writes and reads use different regions to cover the aliases
   task automatic test_registers();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr_val;
      logic [31:0] data;
      a        = random_bits(32);
      b        = random_bits(32);
      addr_val = random_bits(32);
      csr_write(bus_addr(2'b00, persona_pkg::reg_operand_a), a);
      csr_write(bus_addr(2'b01, persona_pkg::reg_operand_b), b);
      csr_write(bus_addr(2'b10, persona_pkg::reg_emif_addr), addr_val);
      csr_read(bus_addr(2'b11, persona_pkg::reg_operand_a), data);
      check_value("reg_operand_a", data, a);
      csr_read(bus_addr(2'b00, persona_pkg::reg_operand_b), data);
      check_value("reg_operand_b", data, b);
      csr_read(bus_addr(2'b01, persona_pkg::reg_emif_addr), data);
      check_value("reg_emif_addr", data, {7'd0, addr_val[24:0]});
      csr_read(bus_addr(2'b00, persona_pkg::reg_persona_id), data);
      check_value("reg_persona_id", data, persona_pkg::persona_id);
      csr_read(bus_addr(2'b11, persona_pkg::reg_persona_id), data);
      check_value("reg_persona_id alias", data, persona_pkg::persona_id);
   endtask

   task automatic test_multiply();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] data;
      for (int n = 0; n < 10; n++) begin
         a = random_bits(32);
         b = random_bits(32);
         run_multiply(a, b);
         csr_read(bus_addr(2'b00, persona_pkg::reg_product), data);
         check_value("reg_product", data, 32'(a[15:0]) * 32'(b[15:0]));
         csr_read(bus_addr(2'b00, persona_pkg::reg_status), data);
         check_value("product_valid", 32'(data[persona_pkg::status_product_valid_bit]), 32'd1);
      end
   endtask

   task automatic test_store(output logic [24:0] addr);
      logic [31:0]  a;
      logic [31:0]  b;
      logic [511:0] word;
      a    = random_bits(32);
      b    = random_bits(32);
      addr = 25'(random_bits(25));
      run_multiply(a, b);
      stall_cycles = 4'(1 + random_bits(3));
      csr_write(bus_addr(2'b00, persona_pkg::reg_emif_addr), 32'(addr));
      csr_write(bus_addr(2'b00, persona_pkg::reg_command), 32'd1 << persona_pkg::cmd_store_bit);
      wait_mover_done();
      word = mem_i.word_at(addr);
      check_value("stored word bits 31:0", word[31:0], 32'(a[15:0]) * 32'(b[15:0]));
      for (int i = 1; i < 16; i++) begin
         check_value($sformatf("stored word bits %0d:%0d", i * 32 + 31, i * 32),
                     word[i*32 +: 32], 32'd0);
      end
   endtask

   task automatic test_load(input logic [24:0] base_addr);
      logic [24:0]  load_addr;
      logic [24:0]  other_addr;
      logic [511:0] word;
      logic [31:0]  data;
      load_addr  = base_addr ^ 25'd1;
      other_addr = base_addr ^ 25'd2;
      for (int i = 0; i < 16; i++) begin
         word[i*32 +: 32] = random_bits(32);
      end
      preload      = 1'b1;
      preload_addr = load_addr;
      preload_data = word;
      step();
      preload = 1'b0;
      // Read latency of at least six keeps the mover busy through the next two writes
      read_delay   = 4'(6 + random_bits(3));
      stall_cycles = 4'(random_bits(2));
      csr_write(bus_addr(2'b00, persona_pkg::reg_emif_addr), 32'(load_addr));
      csr_write(bus_addr(2'b00, persona_pkg::reg_command), 32'd1 << persona_pkg::cmd_load_bit);
      csr_write(bus_addr(2'b00, persona_pkg::reg_emif_addr), 32'(other_addr));
      csr_write(bus_addr(2'b00, persona_pkg::reg_command), 32'd1 << persona_pkg::cmd_store_bit);
      csr_read(bus_addr(2'b00, persona_pkg::reg_status), data);
      check_value("mover_busy during load", 32'(data[persona_pkg::status_mover_busy_bit]), 32'd1);
      wait_mover_done();
      csr_read(bus_addr(2'b00, persona_pkg::reg_loaded_word), data);
      check_value("reg_loaded_word", data, word[31:0]);
      check_value("word written by dropped store", 32'(mem_i.holds_word(other_addr)), 32'd0);
      check_value("preloaded word changed", 32'(mem_i.word_at(load_addr) != word), 32'd0);
   endtask

   initial begin
      lfsr_state     = 32'h954d_66b9;
      rst            = 1'b1;
      start_req      = 1'b0;
      stop_req       = 1'b0;
      avmm_read      = 1'b0;
      avmm_write     = 1'b0;
      avmm_address   = '0;
      avmm_writedata = '0;
      stall_cycles   = 4'd0;
      read_delay     = 4'd0;
      preload        = 1'b0;
      preload_addr   = '0;
      preload_data   = '0;
      repeat (3) @(posedge pr_region_clk);
      #drive_delay;
      rst = 1'b0;
      test_handshake();
      test_registers();
      test_multiply();
      test_store(store_addr);
      test_load(store_addr);
      $display("checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
persona_pkg.sv
csr_bus_if.sv
emif_bus_if.sv
dsp_mult_pipe.sv
emif_result_mover.sv
basic_dsp_persona.sv
basic_dsp_persona_top.sv
tb_emif_model.sv
tb_basic_dsp_persona.sv

// File: Makefile
# Verilator build and run for the DSP persona testbench

VERILATOR ?= verilator
TOP       ?= tb_basic_dsp_persona
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, so a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
